//--- hw/mem_ctl_pkg.sv
// ==========================================================
// Memory controller package
// Memory map, access latencies, store size codes, UART
// register offsets and the request and pin structs shared
// by the cycle-delayed memory model
// ==========================================================

`default_nettype none

package mem_ctl_pkg;

    // Bus widths
    localparam logic [31:0] addr_w = 32'd32;
    localparam logic [31:0] data_w = 32'd32;

    // ======================================================
    // Memory map
    // ======================================================
    localparam logic [31:0] prog_base = 32'h0000_0000;
    localparam logic [31:0] prog_size = 32'h0000_2000;
    localparam logic [31:0] data_base = 32'h0000_2000;
    localparam logic [31:0] data_size = 32'h0000_2000;
    localparam logic [31:0] mem_bytes = 32'd16384;

    localparam logic [31:0] uart_base = 32'h4000_0000;
    localparam logic [31:0] uart_span = 32'd16;

    // Access latencies in cycles
    localparam logic [31:0] instr_fetch_delay = 32'd3;
    localparam logic [31:0] data_access_delay = 32'd2;

    typedef logic [1:0] delay_cnt_t;

    // Store size, same encoding as funct3
    typedef logic [2:0] size_t;
    localparam size_t size_byte = 3'b000;
    localparam size_t size_half = 3'b001;
    localparam size_t size_word = 3'b010;

    // UART register offsets
    localparam logic [3:0] uart_tx_off     = 4'h0;
    localparam logic [3:0] uart_status_off = 4'h4;
    localparam logic [3:0] uart_rx_off     = 4'h8;

    // Status word, tx_busy sits in bit 0
    typedef struct packed {
        logic rx_break;
        logic rx_valid;
        logic tx_busy;
    } uart_status_t;

    // ======================================================
    // Request and pin bundles
    // ======================================================
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        size_t       size;
        logic        we;
    } data_req_t;

    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } uart_tx_t;

    typedef struct packed {
        logic       valid;
        logic       brk;
        logic [7:0] data;
    } uart_rx_t;

endpackage

`default_nettype wire

//--- hw/access_arbiter.sv
// ==========================================================
// Access arbiter
// Runs one memory access at a time, data before fetch.
// Counts the fixed fetch and data latencies, decodes the
// address region and issues the one-cycle ready pulses
// ==========================================================

`default_nettype none

module access_arbiter (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              instr_req,
    input  wire  [mem_ctl_pkg::addr_w-1:0]   instr_addr,
    input  wire  mem_ctl_pkg::data_req_t     mem_req,
    input  wire                              mem_we,
    input  wire                              mem_re,
    input  wire  [mem_ctl_pkg::data_w-1:0]   fetch_word,
    input  wire  [mem_ctl_pkg::data_w-1:0]   load_word,
    input  wire  [mem_ctl_pkg::data_w-1:0]   uart_rdata,
    output logic [mem_ctl_pkg::data_w-1:0]   instr_data,
    output logic                             instr_ready,
    output logic [mem_ctl_pkg::data_w-1:0]   mem_rdata,
    output logic                             mem_ready,
    output mem_ctl_pkg::data_req_t           cur_req,
    output logic [mem_ctl_pkg::addr_w-1:0]   fetch_addr,
    output logic                             ram_we,
    output logic                             uart_sel
);

    typedef enum logic {
        st_idle,
        st_active
    } state_t;

    state_t                  state;
    mem_ctl_pkg::delay_cnt_t cnt;
    logic                    is_fetch;

    logic data_req;
    logic live_uart;
    logic cur_prog;
    logic cur_data;
    logic cur_ram;
    logic fetch_in_range;
    logic done;

    // ======================================================
    // Region decode
    // ======================================================
    assign data_req  = mem_we | mem_re;
    assign live_uart = (mem_req.addr >= mem_ctl_pkg::uart_base) &&
                       (mem_req.addr < mem_ctl_pkg::uart_base + mem_ctl_pkg::uart_span);

    assign cur_prog = (cur_req.addr >= mem_ctl_pkg::prog_base) &&
                      (cur_req.addr < mem_ctl_pkg::prog_base + mem_ctl_pkg::prog_size);
    assign cur_data = (cur_req.addr >= mem_ctl_pkg::data_base) &&
                      (cur_req.addr < mem_ctl_pkg::data_base + mem_ctl_pkg::data_size);
    assign cur_ram  = cur_prog || cur_data;

    // Whole fetch word must lie inside the array
    assign fetch_in_range = fetch_addr <= mem_ctl_pkg::mem_bytes - 32'd4;

    assign done     = (state == st_active) && (cnt == '0);
    // UART accesses bypass the delay and finish on the accept edge
    assign uart_sel = (state == st_idle) && data_req && live_uart;
    // Only data-region stores reach the array
    assign ram_we   = done && !is_fetch && cur_req.we && cur_data;

    // ======================================================
    // Sequencer
    // ======================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            cnt         <= '0;
            is_fetch    <= 1'b0;
            cur_req     <= '0;
            fetch_addr  <= '0;
            instr_data  <= '0;
            instr_ready <= 1'b0;
            mem_rdata   <= '0;
            mem_ready   <= 1'b0;
        end else begin
            instr_ready <= 1'b0;
            mem_ready   <= 1'b0;
            case (state)
                st_idle: begin
                    if (data_req) begin
                        cur_req  <= mem_req;
                        is_fetch <= 1'b0;
                        if (live_uart) begin
                            mem_rdata <= mem_req.we ? '0 : uart_rdata;
                            mem_ready <= 1'b1;
                        end else begin
                            cnt   <= mem_ctl_pkg::delay_cnt_t'(
                                         mem_ctl_pkg::data_access_delay - 32'd1);
                            state <= st_active;
                        end
                    end else if (instr_req) begin
                        fetch_addr <= instr_addr;
                        is_fetch   <= 1'b1;
                        cnt        <= mem_ctl_pkg::delay_cnt_t'(
                                          mem_ctl_pkg::instr_fetch_delay - 32'd1);
                        state      <= st_active;
                    end
                end
                st_active: begin
                    if (cnt == '0) begin
                        state <= st_idle;
                        if (is_fetch) begin
                            instr_data  <= fetch_in_range ? fetch_word : '0;
                            instr_ready <= 1'b1;
                        end else begin
                            // Unmapped loads and all stores return zero
                            mem_rdata <= (cur_ram && !cur_req.we) ? load_word : '0;
                            mem_ready <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Fetch and data completions never overlap
    assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_ready && mem_ready));

    // A UART select is answered on its own edge and leaves the arbiter idle
    assert property (@(posedge clk) disable iff (!rst_n)
        uart_sel |=> (mem_ready && state == st_idle));

endmodule

`default_nettype wire

//--- hw/unified_ram.sv
// ==========================================================
// Unified RAM
// Byte array holding program and data, little-endian.
// Store lanes follow the funct3 size code, both read
// ports return a word combinationally
// ==========================================================

`default_nettype none

module unified_ram (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             we,
    input  wire  mem_ctl_pkg::data_req_t    req,
    input  wire  [mem_ctl_pkg::addr_w-1:0]  fetch_addr,
    output logic [mem_ctl_pkg::data_w-1:0]  fetch_word,
    output logic [mem_ctl_pkg::data_w-1:0]  load_word
);

    logic [7:0] mem [0:mem_ctl_pkg::mem_bytes-1];
    logic [2:0] wr_bytes;

    // Array index of byte k after addr, wrapped into the array
    function automatic logic [31:0] lane(input logic [31:0] addr, input logic [31:0] k);
        return (addr + k) & (mem_ctl_pkg::mem_bytes - 32'd1);
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] w;
        w = {mem[lane(addr, 32'd3)], mem[lane(addr, 32'd2)],
             mem[lane(addr, 32'd1)], mem[lane(addr, 32'd0)]};
        return w;
    endfunction

    // ======================================================
    // Write port
    // ======================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_ctl_pkg::mem_bytes; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (we) begin
            mem[lane(req.addr, 32'd0)] <= req.wdata[7:0];
            if (req.size == mem_ctl_pkg::size_half || req.size == mem_ctl_pkg::size_word) begin
                mem[lane(req.addr, 32'd1)] <= req.wdata[15:8];
            end
            if (req.size == mem_ctl_pkg::size_word) begin
                mem[lane(req.addr, 32'd2)] <= req.wdata[23:16];
                mem[lane(req.addr, 32'd3)] <= req.wdata[31:24];
            end
        end
    end

    // Read ports
    assign fetch_word = read_word(fetch_addr);
    assign load_word  = read_word(req.addr);

    // Bytes touched by the current store
    always_comb begin
        case (req.size)
            mem_ctl_pkg::size_byte: wr_bytes = 3'd1;
            mem_ctl_pkg::size_half: wr_bytes = 3'd2;
            mem_ctl_pkg::size_word: wr_bytes = 3'd4;
            default:                wr_bytes = 3'd1;
        endcase
    end

    // Arbiter only passes stores that fit inside the array
    assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (req.addr + 32'(wr_bytes) <= mem_ctl_pkg::mem_bytes));

endmodule

`default_nettype wire

//--- hw/uart_regs.sv
// ==========================================================
// UART register window
// TX data strobe, status word and RX data register.
// RX valid and break are latched until the byte is read
// ==========================================================

`default_nettype none

module uart_regs (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             sel,
    input  wire  mem_ctl_pkg::data_req_t    req,
    input  wire                             tx_busy,
    input  wire  mem_ctl_pkg::uart_rx_t     rx,
    output mem_ctl_pkg::uart_tx_t           tx,
    output logic                            rx_en,
    output logic [mem_ctl_pkg::data_w-1:0]  rdata
);

    logic                      rx_valid_q;
    logic                      rx_break_q;
    logic [7:0]                rx_data_q;
    logic [3:0]                offset;
    logic                      tx_wr;
    logic                      rx_rd;
    mem_ctl_pkg::uart_status_t status;

    // ======================================================
    // Offset decode
    // ======================================================
    assign offset = req.addr[3:0];
    assign tx_wr  = sel && req.we && (offset == mem_ctl_pkg::uart_tx_off);
    assign rx_rd  = sel && !req.we && (offset == mem_ctl_pkg::uart_rx_off);

    always_comb begin
        status.rx_break = rx_break_q;
        status.rx_valid = rx_valid_q;
        status.tx_busy  = tx_busy;
    end

    // Read mux, unused offsets read as zero
    always_comb begin
        rdata = '0;
        case (offset)
            mem_ctl_pkg::uart_status_off: rdata[$bits(status)-1:0] = status;
            mem_ctl_pkg::uart_rx_off:     rdata[7:0] = rx_data_q;
            default:                      rdata = '0;
        endcase
    end

    // ======================================================
    // Registers
    // ======================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx         <= '0;
            rx_en      <= 1'b0;
            rx_valid_q <= 1'b0;
            rx_break_q <= 1'b0;
            rx_data_q  <= '0;
        end else begin
            // TX strobe fires even when busy, software polls status first
            tx.en <= tx_wr;
            if (tx_wr) begin
                tx.data <= req.wdata[7:0];
            end
            rx_en <= rx_rd;

            // A new byte takes precedence over a read that clears the latch
            if (rx.valid) begin
                rx_valid_q <= 1'b1;
                rx_break_q <= rx.brk;
                rx_data_q  <= rx.data;
            end else if (rx_rd) begin
                rx_valid_q <= 1'b0;
                rx_break_q <= 1'b0;
            end
        end
    end

    // Each UART access is a single select, so the strobe never repeats
    assert property (@(posedge clk) disable iff (!rst_n)
        tx.en |=> !tx.en);

endmodule

`default_nettype wire

//--- hw/mem_ctl.sv
// ==========================================================
// Memory controller top
// Cycle-delayed memory model for an RV32I core with one
// shared byte array and a small UART register window
// ==========================================================

`default_nettype none

module mem_ctl (
    input  wire                             clk,
    input  wire                             rst_n,

    // Instruction fetch port
    input  wire                             instr_req,
    input  wire  [mem_ctl_pkg::addr_w-1:0]  instr_addr,
    output logic [mem_ctl_pkg::data_w-1:0]  instr_data,
    output logic                            instr_ready,

    // Data port
    input  wire  mem_ctl_pkg::data_req_t    mem_req,
    input  wire                             mem_we,
    input  wire                             mem_re,
    output logic [mem_ctl_pkg::data_w-1:0]  mem_rdata,
    output logic                            mem_ready,

    // UART pins
    output mem_ctl_pkg::uart_tx_t           uart_tx,
    output logic                            uart_rx_en,
    input  wire                             uart_tx_busy,
    input  wire  mem_ctl_pkg::uart_rx_t     uart_rx
);

    mem_ctl_pkg::data_req_t         cur_req;
    logic [mem_ctl_pkg::addr_w-1:0] fetch_addr;
    logic [mem_ctl_pkg::data_w-1:0] fetch_word;
    logic [mem_ctl_pkg::data_w-1:0] load_word;
    logic [mem_ctl_pkg::data_w-1:0] uart_rdata;
    logic                           ram_we;
    logic                           uart_sel;

    access_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .fetch_word  (fetch_word),
        .load_word   (load_word),
        .uart_rdata  (uart_rdata),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .cur_req     (cur_req),
        .fetch_addr  (fetch_addr),
        .ram_we      (ram_we),
        .uart_sel    (uart_sel)
    );

    // RAM sees the captured request, UART sees the live one
    unified_ram u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (ram_we),
        .req        (cur_req),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word),
        .load_word  (load_word)
    );

    uart_regs u_uart (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (uart_sel),
        .req     (mem_req),
        .tx_busy (uart_tx_busy),
        .rx      (uart_rx),
        .tx      (uart_tx),
        .rx_en   (uart_rx_en),
        .rdata   (uart_rdata)
    );

endmodule

`default_nettype wire

//--- test/tb_checks.svh
// ==========================================================
// Testbench compare tasks
// Typed compares for data words, UART TX pins and access
// latencies, with the check and error counters
// ==========================================================

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_word(input string name,
                          input logic [mem_ctl_pkg::data_w-1:0] got,
                          input logic [mem_ctl_pkg::data_w-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_tx(input string name,
                        input mem_ctl_pkg::uart_tx_t got,
                        input mem_ctl_pkg::uart_tx_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0t %s got en=%b data=%h expected en=%b data=%h",
                 $time, name, got.en, got.data, exp.en, exp.data);
    end
endtask

task automatic check_latency(input string name, input int got, input int exp);
    check_count++;
    if (got != exp) begin
        error_count++;
        $display("[FAIL] %0t %s got %0d edges expected %0d", $time, name, got, exp);
    end
endtask

// Protocol problems that have no value to compare
task automatic report_error(input string msg);
    error_count++;
    $display("error at %0t: %s", $time, msg);
endtask

`endif

//--- test/tb_mem_ctl.sv
// ==========================================================
// Memory controller testbench
// Table-driven stores, loads, fetches and UART accesses,
// checked against a shadow byte array and fixed latencies
// ==========================================================

`default_nettype none

module tb_mem_ctl;

    typedef enum logic [2:0] {
        op_store, op_load, op_fetch, op_both, op_uart_wr, op_uart_rd, op_rx_inject
    } op_t;

    typedef struct packed {
        op_t                op;
        logic [31:0]        addr;
        logic [31:0]        data;
        mem_ctl_pkg::size_t size;
        logic [31:0]        exp;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_req;
    logic [31:0]            instr_addr;
    logic [31:0]            instr_data;
    logic                   instr_ready;
    mem_ctl_pkg::data_req_t mem_req;
    logic                   mem_we;
    logic                   mem_re;
    logic [31:0]            mem_rdata;
    logic                   mem_ready;
    mem_ctl_pkg::uart_tx_t  uart_tx;
    logic                   uart_rx_en;
    logic                   uart_tx_busy;
    mem_ctl_pkg::uart_rx_t  uart_rx;

    `include "tb_checks.svh"

    row_t        rows[$];
    logic [7:0]  shadow [0:mem_ctl_pkg::mem_bytes-1];
    logic [31:0] rng_state;
    int          cycle_count = 0;
    bit          table_ready = 1'b0;

    mem_ctl u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_req    (instr_req),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .instr_ready  (instr_ready),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_re       (mem_re),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .uart_tx      (uart_tx),
        .uart_rx_en   (uart_rx_en),
        .uart_tx_busy (uart_tx_busy),
        .uart_rx      (uart_rx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // Every row fits in 8 cycles, reset and margin in the rest
    initial begin
        wait (table_ready && cycle_count >= rows.size() * 8 + 50);
        $display("timeout: no completion after %0d cycles", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ======================================================
    // Shadow memory model
    // ======================================================
    function automatic logic [31:0] shadow_bytes(input logic [31:0] addr);
        return {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
    endfunction

    // Only data-region stores land in the array
    task automatic shadow_store(input logic [31:0] addr, input logic [31:0] data,
                                input mem_ctl_pkg::size_t size);
        if (addr >= mem_ctl_pkg::data_base &&
            addr < mem_ctl_pkg::data_base + mem_ctl_pkg::data_size) begin
            shadow[addr] = data[7:0];
            if (size == mem_ctl_pkg::size_half || size == mem_ctl_pkg::size_word) begin
                shadow[addr + 1] = data[15:8];
            end
            if (size == mem_ctl_pkg::size_word) begin
                shadow[addr + 2] = data[23:16];
                shadow[addr + 3] = data[31:24];
            end
        end
    endtask

    function automatic logic [31:0] expected_load(input logic [31:0] addr);
        if (addr < mem_ctl_pkg::data_base + mem_ctl_pkg::data_size) begin
            return shadow_bytes(addr);
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] expected_fetch(input logic [31:0] addr);
        if (addr <= mem_ctl_pkg::mem_bytes - 32'd4) begin
            return shadow_bytes(addr);
        end
        return 32'h0;
    endfunction

    function automatic int latency_for(input op_t op, input logic [31:0] addr);
        if (addr >= mem_ctl_pkg::uart_base &&
            addr < mem_ctl_pkg::uart_base + mem_ctl_pkg::uart_span) begin
            return 0;
        end
        return (op == op_fetch) ? 3 : 2;
    endfunction

    // ======================================================
    // Stimulus table
    // ======================================================
    // Store and TX rows take their data from the generator
    task automatic add_row(input op_t op, input logic [31:0] addr,
                           input mem_ctl_pkg::size_t size, input logic [31:0] data,
                           input logic [31:0] exp);
        row_t r;
        r.op   = op;
        r.addr = addr;
        r.size = size;
        r.data = data;
        r.exp  = exp;
        if (op == op_store || op == op_uart_wr) begin
            rng_state = xorshift(rng_state);
            r.data    = rng_state;
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Store sizes and lane preservation
        add_row(op_store,     32'h0000_2000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_load,      32'h0000_2000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_store,     32'h0000_2001, mem_ctl_pkg::size_byte, 0, 0);
        add_row(op_load,      32'h0000_2000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_store,     32'h0000_2002, mem_ctl_pkg::size_half, 0, 0);
        add_row(op_load,      32'h0000_2000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_store,     32'h0000_2010, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_store,     32'h0000_2013, mem_ctl_pkg::size_byte, 0, 0);
        add_row(op_store,     32'h0000_2010, mem_ctl_pkg::size_half, 0, 0);
        add_row(op_load,      32'h0000_2010, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_store,     32'h0000_3ffc, mem_ctl_pkg::size_word, 0, 0);
        // Fetches see data-port writes
        add_row(op_fetch,     32'h0000_2000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_fetch,     32'h0000_3ffc, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_fetch,     32'h0000_0100, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_both,      32'h0000_2010, mem_ctl_pkg::size_word, 32'h0000_2000, 0);
        // UART window
        add_row(op_uart_wr,   32'h4000_0000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_uart_rd,   32'h4000_0004, mem_ctl_pkg::size_word, 0, 32'h0);
        add_row(op_rx_inject, 32'h0,         mem_ctl_pkg::size_byte, 32'h5a, 0);
        add_row(op_uart_rd,   32'h4000_0004, mem_ctl_pkg::size_word, 0, 32'h2);
        add_row(op_uart_rd,   32'h4000_0008, mem_ctl_pkg::size_word, 0, 32'h5a);
        add_row(op_uart_rd,   32'h4000_0004, mem_ctl_pkg::size_word, 0, 32'h0);
        add_row(op_uart_rd,   32'h4000_000c, mem_ctl_pkg::size_word, 0, 32'h0);
        // Unmapped accesses, the store aliases 0x2000 if it wrapped
        add_row(op_load,      32'h1000_0000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_store,     32'h0001_2000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_load,      32'h0000_2000, mem_ctl_pkg::size_word, 0, 0);
        add_row(op_load,      32'h0000_2010, mem_ctl_pkg::size_word, 0, 0);
    endtask

    // Counts rising edges until the wanted ready is seen at a falling edge
    task automatic wait_ready(input bit fetch_side, output int edges);
        bit seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen) begin
            @(negedge clk);
            edges++;
            if (instr_ready && mem_ready) begin
                report_error("instr_ready and mem_ready high in the same cycle");
            end else if (fetch_side && mem_ready) begin
                report_error("mem_ready without a data request");
            end else if (!fetch_side && instr_ready) begin
                report_error("instr_ready before the data access completed");
            end
            seen = fetch_side ? instr_ready : mem_ready;
        end
    endtask

    task automatic fetch_part(input logic [31:0] addr);
        int          edges;
        logic [31:0] exp_word;
        exp_word   = expected_fetch(addr);
        instr_addr = addr;
        instr_req  = 1'b1;
        wait_ready(1'b1, edges);
        instr_req = 1'b0;
        check_word("instr_data", instr_data, exp_word);
        check_latency("instr_ready", edges - 1, latency_for(op_fetch, addr));
    endtask

    task automatic data_part(input row_t r);
        int                    edges;
        bit                    is_wr;
        mem_ctl_pkg::uart_tx_t tx_exp;
        is_wr         = (r.op == op_store || r.op == op_uart_wr);
        mem_req.addr  = r.addr;
        mem_req.wdata = r.data;
        mem_req.size  = r.size;
        mem_req.we    = is_wr;
        mem_we        = is_wr;
        mem_re        = !is_wr;
        wait_ready(1'b0, edges);
        mem_we  = 1'b0;
        mem_re  = 1'b0;
        mem_req = '0;
        check_latency("mem_ready", edges - 1, latency_for(r.op, r.addr));
        if (r.op == op_store) begin
            shadow_store(r.addr, r.data, r.size);
        end else if (r.op == op_uart_rd) begin
            check_word("mem_rdata", mem_rdata, r.exp);
        end else if (r.op != op_uart_wr) begin
            check_word("mem_rdata", mem_rdata, expected_load(r.addr));
        end
        tx_exp.en   = (r.op == op_uart_wr);
        tx_exp.data = (r.op == op_uart_wr) ? r.data[7:0] : 8'h00;
        if (r.op == op_uart_wr || uart_tx.en) begin
            check_tx("uart_tx", uart_tx, tx_exp);
        end
        if (uart_rx_en !== (r.op == op_uart_rd && r.addr[3:0] == mem_ctl_pkg::uart_rx_off)) begin
            report_error("uart_rx_en does not match the register read");
        end
    endtask

    task automatic run_row(input row_t r);
        case (r.op)
            op_rx_inject: begin
                uart_rx.valid = 1'b1;
                uart_rx.brk   = 1'b0;
                uart_rx.data  = r.data[7:0];
            end
            op_fetch: fetch_part(r.addr);
            op_both: begin
                // Load and fetch raised together, the load must win
                instr_addr = r.data;
                instr_req  = 1'b1;
                data_part(r);
                fetch_part(r.data);
            end
            default: data_part(r);
        endcase
        @(negedge clk);
        uart_rx = '0;
        if (instr_ready || mem_ready) begin
            report_error("ready stayed high for more than one cycle");
        end
        if (uart_tx.en || uart_rx_en) begin
            report_error("UART strobe stayed high for more than one cycle");
        end
    endtask

    // ======================================================
    // Main sequence
    // ======================================================
    initial begin
        int errors_before;
        int failed_tests;
        rst_n        = 1'b0;
        instr_req    = 1'b0;
        instr_addr   = '0;
        mem_req      = '0;
        mem_we       = 1'b0;
        mem_re       = 1'b0;
        uart_tx_busy = 1'b0;
        uart_rx      = '0;
        failed_tests = 0;
        for (int i = 0; i < mem_ctl_pkg::mem_bytes; i++) begin
            shadow[i] = 8'h00;
        end
        rng_state = 32'hca58977c;
        build_table();
        table_ready = 1'b1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        foreach (rows[i]) begin
            errors_before = error_count;
            run_row(rows[i]);
            if (error_count == errors_before) begin
                $display("test %0d %s at %h: ok", i, rows[i].op.name(), rows[i].addr);
            end else begin
                failed_tests++;
                $display("test %0d %s at %h: error", i, rows[i].op.name(), rows[i].addr);
            end
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 rows.size(), failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+test
hw/mem_ctl_pkg.sv
hw/access_arbiter.sv
hw/unified_ram.sv
hw/uart_regs.sv
hw/mem_ctl.sv
test/tb_mem_ctl.sv

//--- Bender.yml
package:
  name: mem_ctl

sources:
  # RTL in compile order
  - files:
      - hw/mem_ctl_pkg.sv
      - hw/access_arbiter.sv
      - hw/unified_ram.sv
      - hw/uart_regs.sv
      - hw/mem_ctl.sv

  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mem_ctl.sv
